// ==== zap_decode_pkg.sv ====
// Shared types and constants for the decode front; imported by every decode module.

`default_nettype none

package zap_decode_pkg;

        // One fetched ARM instruction word.
        typedef logic [31:0] instr_t;

        // One micro-op.
        // Bit 32 marks the high half of a split long multiply,
        // bits 31:0 carry the instruction word unchanged.
        typedef logic [32:0] uop_t;

        // Long multiply detection (UMULL, UMLAL, SMULL, SMLAL).
        // Bits 27:23 must read 00001 and bits 7:4 must read 1001.
        // Bit 22 picks signed and bit 21 picks accumulate, so
        // they are left out of the mask and all four forms match.
        localparam instr_t LMULT_MASK  = 32'h0F80_00F0;
        localparam instr_t LMULT_MATCH = 32'h0080_0090;

        // Instruction queue geometry.
        // Depth is a power of two so the pointers wrap for free.
        localparam int QUEUE_DEPTH = 4;
        localparam int QUEUE_PTR_W = 2;

        // Long multiply splitter states.
        // IDLE  : head is new, ordinary or low half of a multiply.
        // BUSY  : low half already sent, high half goes out next.
        typedef enum logic {
                IDLE = 1'b0,
                BUSY = 1'b1
        } mult_state_t;

endpackage

`default_nettype wire

// ==== zap_fetch_queue.sv ====
// Small first-word-fall-through instruction queue between fetch and the decode splitter.

`timescale 1ns/1ps
`default_nettype none

module zap_fetch_queue
        import zap_decode_pkg::*;
(
        // Clock and reset.
        input  wire             i_clk,
        input  wire             i_reset,

        // Flush from later stages.
        input  wire             i_clear,

        // From fetch.
        input  instr_t          i_instruction,
        input  wire             i_instruction_valid,

        // From the splitter.
        input  wire             i_pop,

        // Head of queue, visible without a read request.
        output instr_t          o_head,
        output logic            o_head_valid,

        // Back to fetch.
        output logic            o_full
);

// Storage.
instr_t mem [QUEUE_DEPTH];

// Pointers and occupancy.
logic [QUEUE_PTR_W-1:0] rd_ptr_ff;
logic [QUEUE_PTR_W-1:0] wr_ptr_ff;
logic [QUEUE_PTR_W:0]   count_ff;

logic push;
logic pop;

// Status.
assign o_head_valid = (count_ff != '0);
assign o_full       = (count_ff == (QUEUE_PTR_W+1)'(QUEUE_DEPTH));

// Fetch is not supposed to write when full; guard anyway.
assign push = i_instruction_valid && !o_full;
assign pop  = i_pop && o_head_valid;

// First word falls through.
assign o_head = mem[rd_ptr_ff];

// Control state.
always_ff @(posedge i_clk)
begin
        if ( i_reset || i_clear )
        begin
                rd_ptr_ff <= '0;
                wr_ptr_ff <= '0;
                count_ff  <= '0;
        end
        else
        begin
                if ( push )
                        wr_ptr_ff <= wr_ptr_ff + 1'b1;

                if ( pop )
                        rd_ptr_ff <= rd_ptr_ff + 1'b1;

                // Occupancy follows push and pop together.
                case ( {push, pop} )
                        2'b10:   count_ff <= count_ff + 1'b1;
                        2'b01:   count_ff <= count_ff - 1'b1;
                        default: count_ff <= count_ff;
                endcase
        end
end

// Payload storage.
always_ff @(posedge i_clk)
begin
        if ( push )
                mem[wr_ptr_ff] <= i_instruction;
end

endmodule

`default_nettype wire

// ==== zap_decode_mult_fsm.sv ====
// Splits long multiplies at the queue head into low and high micro-ops for the output register.

`timescale 1ns/1ps
`default_nettype none

module zap_decode_mult_fsm
        import zap_decode_pkg::*;
(
        // Clock and reset.
        input  wire             i_clk,
        input  wire             i_reset,

        // Flush.
        input  wire             i_clear,

        // Head of the instruction queue.
        input  instr_t          i_head,
        input  wire             i_head_valid,

        // Output register can take a micro-op.
        input  wire             i_ready,

        // Interrupt levels.
        input  wire             i_irq,
        input  wire             i_fiq,

        // Consume the head.
        output logic            o_pop,

        // Next micro-op.
        output uop_t            o_uop,
        output logic            o_uop_valid,

        // Interrupts, masked on high halves.
        output logic            o_irq,
        output logic            o_fiq
);

mult_state_t state_ff;
mult_state_t state_nxt;

logic head_is_lmult;

// Long multiply pattern match.
assign head_is_lmult = ((i_head & LMULT_MASK) == LMULT_MATCH);

always_comb
begin
        // Default is a plain pass-through.
        state_nxt   = state_ff;
        o_pop       = 1'b0;
        o_uop       = {1'b0, i_head};
        o_uop_valid = i_head_valid;
        o_irq       = i_irq;
        o_fiq       = i_fiq;

        case ( state_ff )
                IDLE:
                begin
                        if ( i_head_valid )
                        begin
                                // Low half goes out, head stays put.
                                if ( head_is_lmult )
                                        state_nxt = BUSY;
                                else
                                        o_pop = i_ready;
                        end
                end

                BUSY:
                begin
                        // High half; no interrupt may land between the halves.
                        o_uop     = {1'b1, i_head};
                        o_irq     = 1'b0;
                        o_fiq     = 1'b0;
                        o_pop     = i_ready && i_head_valid;
                        state_nxt = IDLE;
                end

                default:
                begin
                        state_nxt = IDLE;
                end
        endcase
end

// State only moves when the output register takes the micro-op.
always_ff @(posedge i_clk)
begin
        if ( i_reset || i_clear )
                state_ff <= IDLE;
        else if ( i_ready )
                state_ff <= state_nxt;
end

endmodule

`default_nettype wire

// ==== zap_decode_out_reg.sv ====
// Decode output register that presents micro-ops to issue and holds them while issue stalls.

`timescale 1ns/1ps
`default_nettype none

module zap_decode_out_reg
        import zap_decode_pkg::*;
(
        // Clock and reset.
        input  wire             i_clk,
        input  wire             i_reset,

        // Flush and issue back-pressure.
        input  wire             i_clear,
        input  wire             i_stall,

        // From the splitter.
        input  uop_t            i_uop,
        input  wire             i_uop_valid,
        input  wire             i_irq,
        input  wire             i_fiq,

        // Back to the splitter.
        output logic            o_ready,

        // To issue.
        output uop_t            o_uop,
        output logic            o_uop_valid,
        output logic            o_irq,
        output logic            o_fiq
);

// Room for a new micro-op when empty or when issue takes the current one.
assign o_ready = !o_uop_valid || !i_stall;

// Valid and interrupt levels.
always_ff @(posedge i_clk)
begin
        if ( i_reset || i_clear )
        begin
                o_uop_valid <= 1'b0;
                o_irq       <= 1'b0;
                o_fiq       <= 1'b0;
        end
        else if ( o_ready )
        begin
                o_uop_valid <= i_uop_valid;
                o_irq       <= i_irq;
                o_fiq       <= i_fiq;
        end
end

// Micro-op payload.
always_ff @(posedge i_clk)
begin
        if ( o_ready )
                o_uop <= i_uop;
end

endmodule

`default_nettype wire

// ==== zap_decode_front.sv ====
// Top level of the decode front; joins the instruction queue, multiply splitter and output register.

`timescale 1ns/1ps
`default_nettype none

module zap_decode_front
        import zap_decode_pkg::*;
(
        // Clock and reset.
        input  wire             i_clk,
        input  wire             i_reset,

        // From fetch.
        input  instr_t          i_instruction,
        input  wire             i_instruction_valid,

        // Interrupt levels.
        input  wire             i_irq,
        input  wire             i_fiq,

        // Issue stall and pipeline flush.
        input  wire             i_stall,
        input  wire             i_clear,

        // To issue.
        output uop_t            o_uop,
        output logic            o_uop_valid,
        output logic            o_irq,
        output logic            o_fiq,

        // Back to fetch.
        output logic            o_stall_to_fetch
);

// Queue to splitter.
instr_t head_instr;
logic   head_valid;
logic   head_pop;

// Splitter to output register.
uop_t   split_uop;
logic   split_uop_valid;
logic   split_irq;
logic   split_fiq;
logic   out_ready;

zap_fetch_queue u_fetch_queue (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear                (i_clear),
        .i_instruction          (i_instruction),
        .i_instruction_valid    (i_instruction_valid),
        .i_pop                  (head_pop),
        .o_head                 (head_instr),
        .o_head_valid           (head_valid),
        .o_full                 (o_stall_to_fetch)
);

zap_decode_mult_fsm u_mult_fsm (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear                (i_clear),
        .i_head                 (head_instr),
        .i_head_valid           (head_valid),
        .i_ready                (out_ready),
        .i_irq                  (i_irq),
        .i_fiq                  (i_fiq),
        .o_pop                  (head_pop),
        .o_uop                  (split_uop),
        .o_uop_valid            (split_uop_valid),
        .o_irq                  (split_irq),
        .o_fiq                  (split_fiq)
);

zap_decode_out_reg u_out_reg (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear                (i_clear),
        .i_stall                (i_stall),
        .i_uop                  (split_uop),
        .i_uop_valid            (split_uop_valid),
        .i_irq                  (split_irq),
        .i_fiq                  (split_fiq),
        .o_ready                (out_ready),
        .o_uop                  (o_uop),
        .o_uop_valid            (o_uop_valid),
        .o_irq                  (o_irq),
        .o_fiq                  (o_fiq)
);

endmodule

`default_nettype wire

// ==== zap_decode_front_chk.sv ====
// Concurrent assertions on the decode front ports; bound into every zap_decode_front instance.

`timescale 1ns/1ps
`default_nettype none

module zap_decode_front_chk
        import zap_decode_pkg::*;
(
        input  wire             i_clk,
        input  wire             i_reset,
        input  wire             i_clear,
        input  wire             i_stall,
        input  uop_t            i_uop,
        input  wire             i_uop_valid,
        input  wire             i_uop_irq,
        input  wire             i_uop_fiq,
        input  mult_state_t     i_mult_state
);

// Clear empties the output register on the next edge.
a_clear_drops_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        i_clear |=> !i_uop_valid)
        else $error("Micro-op still valid in the cycle after clear");

// Splitter restarts from IDLE.
a_clear_idles_fsm: assert property (@(posedge i_clk) disable iff (i_reset)
        i_clear |=> (i_mult_state == IDLE))
        else $error("Splitter not in IDLE in the cycle after clear");

// Held micro-op and its interrupt levels do not move under issue stall.
a_stall_holds: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_uop_valid && i_stall && !i_clear) |=>
        (i_uop_valid && $stable(i_uop) && $stable(i_uop_irq) && $stable(i_uop_fiq)))
        else $error("Issued micro-op changed while issue was stalled");

// No interrupt may land between the halves of a long multiply.
a_high_half_masked: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_uop_valid && i_uop[32]) |-> (!i_uop_irq && !i_uop_fiq))
        else $error("Interrupt level high on a high-half micro-op");

endmodule

bind zap_decode_front zap_decode_front_chk u_decode_front_chk (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear                (i_clear),
        .i_stall                (i_stall),
        .i_uop                  (o_uop),
        .i_uop_valid            (o_uop_valid),
        .i_uop_irq              (o_irq),
        .i_uop_fiq              (o_fiq),
        .i_mult_state           (u_mult_fsm.state_ff)
);

`default_nettype wire

// ==== tb_zap_decode_front.sv ====
// Testbench for the decode front; drives instruction streams and checks every micro-op issued.

`timescale 1ns/1ps
`default_nettype none

module tb_zap_decode_front
        import zap_decode_pkg::*;
();

logic   i_clk;
logic   i_reset;
instr_t i_instruction;
logic   i_instruction_valid;
logic   i_irq;
logic   i_fiq;
logic   i_stall;
logic   i_clear;
uop_t   o_uop;
logic   o_uop_valid;
logic   o_irq;
logic   o_fiq;
logic   o_stall_to_fetch;

// Expected micro-ops in issue order.
uop_t   exp_q [$];
int     errors = 0;
int     cycle_count = 0;
integer seed = 43;
logic   rand_stall = 1'b0;

zap_decode_front u_zap_decode_front (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_instruction          (i_instruction),
        .i_instruction_valid    (i_instruction_valid),
        .i_irq                  (i_irq),
        .i_fiq                  (i_fiq),
        .i_stall                (i_stall),
        .i_clear                (i_clear),
        .o_uop                  (o_uop),
        .o_uop_valid            (o_uop_valid),
        .o_irq                  (o_irq),
        .o_fiq                  (o_fiq),
        .o_stall_to_fetch       (o_stall_to_fetch)
);

initial
begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
end

// Run limit, well above the length of all tests together.
always @(posedge i_clk)
begin
        cycle_count = cycle_count + 1;
        if ( cycle_count >= 3000 )
        begin
                $display("Timeout: run did not finish within %0d cycles", cycle_count);
                $display("Errors: %0d", errors);
                $display("TEST FAIL");
                $finish;
        end
end

// Reference split rule: UMULL, UMLAL, SMULL and SMLAL give two micro-ops.
function automatic int uop_count(input instr_t w);
        uop_count = ((w[27:23] == 5'b00001) && (w[7:4] == 4'b1001)) ? 2 : 1;
endfunction

// Index 0 is the whole word or the low half; index 1 the high half.
function automatic uop_t expected_uop(input instr_t w, input int idx);
        expected_uop = {(idx == 1), w};
endfunction

function automatic instr_t random_word(input logic want_lmult);
        instr_t w;
        w = $random(seed);
        if ( want_lmult )
        begin
                w[27:23] = 5'b00001;
                w[7:4]   = 4'b1001;
        end
        else if ( uop_count(w) == 2 )
                w[4] = 1'b0;
        random_word = w;
endfunction

task automatic check_level(input string name, input logic exp_val, input logic act_val);
        if ( act_val !== exp_val )
        begin
                $display("Fail %s: expected %h, got %h", name, exp_val, act_val);
                errors++;
        end
endtask

// Moves to 1 ns after the next rising edge.
task automatic step();
        @(posedge i_clk);
        #1;
        i_instruction_valid = 1'b0;
        if ( rand_stall )
                i_stall = (($random(seed) & 3) == 0);
endtask

task automatic send_word(input instr_t w);
        int i;
        step();
        // Fetch holds off while the queue is full.
        while ( o_stall_to_fetch )
                step();
        i_instruction       = w;
        i_instruction_valid = 1'b1;
        for ( i = 0; i < uop_count(w); i++ )
                exp_q.push_back(expected_uop(w, i));
endtask

task automatic drain();
        int n;
        rand_stall = 1'b0;
        i_stall    = 1'b0;
        n          = 0;
        while ( (exp_q.size() != 0 || o_uop_valid) && n < 64 )
        begin
                step();
                n++;
        end
        if ( exp_q.size() != 0 )
        begin
                $display("Stream drained with %0d micro-ops never issued", exp_q.size());
                errors++;
                exp_q.delete();
        end
endtask

task automatic pulse_clear();
        step();
        i_clear = 1'b1;
        // Everything queued or in flight is dropped.
        exp_q.delete();
        step();
        i_clear = 1'b0;
        check_level("o_uop_valid", 1'b0, o_uop_valid);
        check_level("o_stall_to_fetch", 1'b0, o_stall_to_fetch);
endtask

// A micro-op is issued when valid and not stalled; clear drops it instead.
always @(negedge i_clk)
begin
        uop_t exp_uop;
        logic exp_irq;
        logic exp_fiq;
        if ( !i_reset && !i_clear && o_uop_valid && !i_stall )
        begin
                if ( exp_q.size() == 0 )
                begin
                        $display("Micro-op %h issued with nothing expected", o_uop);
                        errors++;
                end
                else
                begin
                        exp_uop = exp_q.pop_front();
                        // Levels pass through except on a high half.
                        exp_irq = exp_uop[32] ? 1'b0 : i_irq;
                        exp_fiq = exp_uop[32] ? 1'b0 : i_fiq;
                        if ( o_uop !== exp_uop )
                        begin
                                $display("Fail o_uop: expected %h, got %h", exp_uop, o_uop);
                                errors++;
                        end
                        if ( o_irq !== exp_irq )
                        begin
                                $display("Fail o_irq: expected %h, got %h", exp_irq, o_irq);
                                errors++;
                        end
                        if ( o_fiq !== exp_fiq )
                        begin
                                $display("Fail o_fiq: expected %h, got %h", exp_fiq, o_fiq);
                                errors++;
                        end
                end
        end
end

initial
begin
        int i;
        int accepted;

        i_reset             = 1'b1;
        i_instruction       = '0;
        i_instruction_valid = 1'b0;
        i_irq               = 1'b0;
        i_fiq               = 1'b0;
        i_stall             = 1'b0;
        i_clear             = 1'b0;
        repeat (5) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        check_level("o_uop_valid", 1'b0, o_uop_valid);
        check_level("o_stall_to_fetch", 1'b0, o_stall_to_fetch);
        check_level("o_irq", 1'b0, o_irq);
        check_level("o_fiq", 1'b0, o_fiq);

        // Ordinary words back to back, first one out two edges after input.
        for ( i = 0; i < 8; i++ )
        begin
                send_word(random_word(1'b0));
                check_level("o_uop_valid", (i >= 2), o_uop_valid);
        end
        step();
        check_level("o_uop_valid", 1'b1, o_uop_valid);
        step();
        check_level("o_uop_valid", 1'b1, o_uop_valid);
        step();
        check_level("o_uop_valid", 1'b0, o_uop_valid);
        drain();

        // All four long multiply forms between near misses.
        send_word(32'hE081_0002);
        send_word(32'hE082_1493);
        send_word(32'hE000_0291);
        send_word(32'hE0C5_4392);
        send_word(32'hE0A7_6594);
        send_word(32'hE0E9_8796);
        send_word(32'hE1A0_0000);
        drain();

        // Interrupt levels held high.
        i_irq = 1'b1;
        i_fiq = 1'b1;
        for ( i = 0; i < 6; i++ )
                send_word(random_word(i[0]));
        drain();
        i_fiq = 1'b0;
        for ( i = 0; i < 4; i++ )
                send_word(random_word(!i[0]));
        drain();
        i_irq = 1'b0;

        // Mixed stream under random issue stall.
        rand_stall = 1'b1;
        for ( i = 0; i < 150; i++ )
        begin
                if ( ($random(seed) & 7) == 0 )
                        step();
                else
                        send_word(random_word(($random(seed) & 3) == 0));
        end
        drain();

        // Issue stalled until fetch is held off.
        i_stall  = 1'b1;
        accepted = 0;
        step();
        while ( !o_stall_to_fetch && accepted < QUEUE_DEPTH + 4 )
        begin
                send_now(random_word(1'b0));
                accepted++;
        end
        if ( accepted != QUEUE_DEPTH + 1 )
        begin
                $display("Fetch stall rose after %0d words instead of %0d",
                        accepted, QUEUE_DEPTH + 1);
                errors++;
        end
        repeat (3)
        begin
                step();
                check_level("o_stall_to_fetch", 1'b1, o_stall_to_fetch);
        end
        i_stall = 1'b0;
        for ( i = 0; i < 4; i++ )
                send_word(random_word(1'b0));
        drain();

        // Clear while the high half of a long multiply is next.
        send_word(32'hE082_1493);
        step();
        pulse_clear();
        send_word(32'hE1A0_0000);
        send_word(32'hE0C5_4392);
        drain();

        // Clear under stall with the queue full, then in a running stream.
        i_stall = 1'b1;
        send_word(random_word(1'b0));
        send_word(random_word(1'b1));
        send_word(random_word(1'b1));
        send_word(random_word(1'b0));
        send_word(random_word(1'b0));
        pulse_clear();
        i_stall = 1'b0;
        for ( i = 0; i < 5; i++ )
                send_word(random_word(i == 2));
        pulse_clear();
        for ( i = 0; i < 5; i++ )
                send_word(random_word(i == 1));
        drain();

        $display("Errors: %0d", errors);
        if ( errors == 0 )
                $display("TEST PASS");
        else
                $display("TEST FAIL");
        $finish;
end

// Drives one word in the current cycle and steps to the next.
task automatic send_now(input instr_t w);
        int i;
        i_instruction       = w;
        i_instruction_valid = 1'b1;
        for ( i = 0; i < uop_count(w); i++ )
                exp_q.push_back(expected_uop(w, i));
        step();
endtask

endmodule

`default_nettype wire

// ==== tb.f ====
zap_decode_pkg.sv
zap_fetch_queue.sv
zap_decode_mult_fsm.sv
zap_decode_out_reg.sv
zap_decode_front.sv
zap_decode_front_chk.sv
tb_zap_decode_front.sv

// ==== run.sh ====
#!/bin/bash
# Builds the decode front testbench with Verilator and runs it.
set -e -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_zap_decode_front \
        -f tb.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
        echo "Simulation reported failure"
        exit 1
fi

echo "Simulation finished without failure"
